// ==== common/tlb_pkg.sv ====
package tlb_pkg;

    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = 4;   // log2 of tlb_num.

    localparam int asid_w    = 10;
    localparam int vppn_w    = 19;  // va bits 31 to 13 name one pair of pages.
    localparam int ppn_w     = 20;
    localparam int ps_w      = 6;

    // page size code for 4 KB pages. Any other code is treated as 4 MB.
    localparam logic [ps_w-1:0] ps_4k = 6'd12;

    localparam int seg_w     = 3;   // the direct-map window segment is va bits 31 to 29.

    localparam int off_4k_w  = 12;
    localparam int off_4m_w  = 22;
    localparam int vppn_hi_w = 9;   // vppn bits compared for a 4 MB pair.

    // the same virtual address seen as a 4 KB page or as a 4 MB page.
    typedef union packed {
        struct packed {
            logic [vppn_w-1:0]   vppn;
            logic                odd;      // bit 12 picks the odd page.
            logic [off_4k_w-1:0] offset;
        } page_4k;
        struct packed {
            logic [vppn_hi_w-1:0] vppn_hi;
            logic                 odd;     // bit 22 picks the odd page.
            logic [off_4m_w-1:0]  offset;
        } page_4m;
    } va_t;

endpackage

// ==== common/tlb_entry_if.sv ====
interface tlb_entry_if import tlb_pkg::*; ();

    // one element per entry, indexed by entry number.
    logic [tlb_num-1:0]             e;
    logic [tlb_num-1:0][asid_w-1:0] asid;
    logic [tlb_num-1:0]             g;
    logic [tlb_num-1:0][ps_w-1:0]   ps;
    logic [tlb_num-1:0][vppn_w-1:0] vppn;
    logic [tlb_num-1:0]             v0;    // even page valid.
    logic [tlb_num-1:0][ppn_w-1:0]  ppn0;
    logic [tlb_num-1:0]             v1;    // odd page valid.
    logic [tlb_num-1:0][ppn_w-1:0]  ppn1;

    modport array (
        output e, asid, g, ps, vppn,
        output v0, ppn0, v1, ppn1
    );

    modport match (
        input e, asid, g, ps, vppn,
        input v0, ppn0, v1, ppn1
    );

endinterface

// ==== common/tlb_result_if.sv ====
interface tlb_result_if import tlb_pkg::*; ();

    logic             hit;    // some entry matched the sampled address.
    logic             is_4k;
    logic             v;      // valid bit of the chosen page.
    logic [ppn_w-1:0] ppn;

    modport match (
        output hit,
        output is_4k,
        output v,
        output ppn
    );

    modport xlate (
        input hit,
        input is_4k,
        input v,
        input ppn
    );

endinterface

// ==== tlb/tlb_array.sv ====
module tlb_array import tlb_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic                 we,
    input  logic [tlb_idx_w-1:0] windex,
    input  logic                 w_e,
    input  logic                 w_g,
    input  logic [asid_w-1:0]    w_asid,
    input  logic [ps_w-1:0]      w_ps,
    input  logic [vppn_w-1:0]    w_vppn,
    input  logic                 w_v0,
    input  logic                 w_v1,
    input  logic [ppn_w-1:0]     w_ppn0,
    input  logic [ppn_w-1:0]     w_ppn1,

    tlb_entry_if.array           ent
);

    // compare part of each entry.
    logic [tlb_num-1:0]             e_q;
    logic [tlb_num-1:0][asid_w-1:0] asid_q;
    logic [tlb_num-1:0]             g_q;
    logic [tlb_num-1:0][ps_w-1:0]   ps_q;
    logic [tlb_num-1:0][vppn_w-1:0] vppn_q;

    // translate part, even and odd page.
    logic [tlb_num-1:0]             v0_q;
    logic [tlb_num-1:0][ppn_w-1:0]  ppn0_q;
    logic [tlb_num-1:0]             v1_q;
    logic [tlb_num-1:0][ppn_w-1:0]  ppn1_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            e_q    <= '0;  // every entry starts disabled.
            asid_q <= '0;
            g_q    <= '0;
            ps_q   <= '0;
            vppn_q <= '0;
            v0_q   <= '0;
            ppn0_q <= '0;
            v1_q   <= '0;
            ppn1_q <= '0;
        end else if (we) begin
            // the whole entry is replaced, as a TLB fill does.
            e_q[windex]    <= w_e;
            asid_q[windex] <= w_asid;
            g_q[windex]    <= w_g;
            ps_q[windex]   <= w_ps;
            vppn_q[windex] <= w_vppn;
            v0_q[windex]   <= w_v0;
            ppn0_q[windex] <= w_ppn0;
            v1_q[windex]   <= w_v1;
            ppn1_q[windex] <= w_ppn1;
        end
    end

    // contents go straight out, both matchers see the same entries.
    assign ent.e    = e_q;
    assign ent.asid = asid_q;
    assign ent.g    = g_q;
    assign ent.ps   = ps_q;
    assign ent.vppn = vppn_q;
    assign ent.v0   = v0_q;
    assign ent.ppn0 = ppn0_q;
    assign ent.v1   = v1_q;
    assign ent.ppn1 = ppn1_q;

endmodule

// ==== tlb/tlb_match.sv ====
module tlb_match import tlb_pkg::*; (
    input  logic              clk,
    input  logic              rstn,

    input  va_t               va,
    input  logic [asid_w-1:0] csr_asid,

    tlb_entry_if.match        ent,
    tlb_result_if.match       res
);

    logic [tlb_num-1:0] hit_4k_d;
    logic [tlb_num-1:0] hit_4m_d;
    logic [tlb_num-1:0] is_4k_d;

    logic [tlb_num-1:0] hit_4k_q;
    logic [tlb_num-1:0] hit_4m_q;
    logic [tlb_num-1:0] is_4k_q;
    logic               odd_4k_q;
    logic               odd_4m_q;

    logic [tlb_num-1:0]   hit_vec;
    logic [tlb_idx_w-1:0] sel;
    logic                 hit_any;
    logic                 sel_4k;
    logic                 sel_odd;

    // compare stage, both page sizes are tried against every entry.
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            logic asid_ok;
            asid_ok     = ent.e[i] & (ent.g[i] | (ent.asid[i] == csr_asid));
            hit_4k_d[i] = asid_ok & (ent.vppn[i] == va.page_4k.vppn);
            hit_4m_d[i] = asid_ok &
                          (ent.vppn[i][vppn_w-1 -: vppn_hi_w] == va.page_4m.vppn_hi);
            is_4k_d[i]  = (ent.ps[i] == ps_4k);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hit_4k_q <= '0;
            hit_4m_q <= '0;
            is_4k_q  <= '0;
            odd_4k_q <= 1'b0;
            odd_4m_q <= 1'b0;
        end else begin
            hit_4k_q <= hit_4k_d;
            hit_4m_q <= hit_4m_d;
            is_4k_q  <= is_4k_d;
            odd_4k_q <= va.page_4k.odd;
            odd_4m_q <= va.page_4m.odd;
        end
    end

    // the page size of each entry decides which compare counts.
    always_comb begin
        for (int i = 0; i < tlb_num; i++) begin
            hit_vec[i] = is_4k_q[i] ? hit_4k_q[i] : hit_4m_q[i];
        end
    end

    // scanning downwards leaves the lowest hitting index in sel.
    always_comb begin
        sel     = '0;
        hit_any = 1'b0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                sel     = tlb_idx_w'(i);
                hit_any = 1'b1;
            end
        end
    end

    assign sel_4k  = is_4k_q[sel];
    assign sel_odd = sel_4k ? odd_4k_q : odd_4m_q;

    // page fields are read from the live entry after the register.
    assign res.hit   = hit_any;
    assign res.is_4k = sel_4k;
    assign res.v     = sel_odd ? ent.v1[sel] : ent.v0[sel];
    assign res.ppn   = sel_odd ? ent.ppn1[sel] : ent.ppn0[sel];

endmodule

// ==== logic/addr_translate.sv ====
module addr_translate import tlb_pkg::*; (
    input  logic             clk,
    input  logic             rstn,

    input  va_t              va,
    input  logic             pg,
    input  logic [seg_w-1:0] dmw0_vseg,
    input  logic [seg_w-1:0] dmw0_pseg,
    input  logic [seg_w-1:0] dmw1_vseg,
    input  logic [seg_w-1:0] dmw1_pseg,

    tlb_result_if.xlate      res,

    output logic [31:0]      pa,
    output logic             miss,
    output logic             inval
);

    va_t              va_q;
    logic             pg_q;
    logic [seg_w-1:0] dmw0_vseg_q;
    logic [seg_w-1:0] dmw0_pseg_q;
    logic [seg_w-1:0] dmw1_vseg_q;
    logic [seg_w-1:0] dmw1_pseg_q;

    logic             dmw0_hit;
    logic             dmw1_hit;

    // same stage as the matcher registers.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            va_q <= '0;
            pg_q <= 1'b0;  // outputs read as direct pass-through after reset.
        end else begin
            va_q <= va;
            pg_q <= pg;
        end
    end

    always_ff @(posedge clk) begin
        dmw0_vseg_q <= dmw0_vseg;
        dmw0_pseg_q <= dmw0_pseg;
        dmw1_vseg_q <= dmw1_vseg;
        dmw1_pseg_q <= dmw1_pseg;
    end

    assign dmw0_hit = (va_q[31 -: seg_w] == dmw0_vseg_q);
    assign dmw1_hit = (va_q[31 -: seg_w] == dmw1_vseg_q);

    always_comb begin
        pa    = va_q;
        miss  = 1'b0;
        inval = 1'b0;
        if (pg_q) begin
            if (dmw0_hit) begin
                pa = {dmw0_pseg_q, va_q[31-seg_w:0]};  // window 0 wins over window 1.
            end else if (dmw1_hit) begin
                pa = {dmw1_pseg_q, va_q[31-seg_w:0]};
            end else if (!res.hit) begin
                pa   = '0;
                miss = 1'b1;
            end else if (!res.v) begin
                pa    = '0;
                inval = 1'b1;
            end else if (res.is_4k) begin
                pa = {res.ppn, va_q.page_4k.offset};
            end else begin
                pa = {res.ppn[ppn_w-1 -: 32-off_4m_w], va_q.page_4m.offset};
            end
        end
    end

endmodule

// ==== logic/mmu_top.sv ====
module mmu_top import tlb_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,

    input  logic [asid_w-1:0]    csr_asid,
    input  logic                 pg,
    input  logic [seg_w-1:0]     dmw0_vseg,
    input  logic [seg_w-1:0]     dmw0_pseg,
    input  logic [seg_w-1:0]     dmw1_vseg,
    input  logic [seg_w-1:0]     dmw1_pseg,

    input  logic [31:0]          va_i,
    input  logic [31:0]          va_d,

    input  logic                 tlb_we,
    input  logic [tlb_idx_w-1:0] tlb_windex,
    input  logic                 w_e,
    input  logic [asid_w-1:0]    w_asid,
    input  logic                 w_g,
    input  logic [ps_w-1:0]      w_ps,
    input  logic [vppn_w-1:0]    w_vppn,
    input  logic                 w_v0,
    input  logic [ppn_w-1:0]     w_ppn0,
    input  logic                 w_v1,
    input  logic [ppn_w-1:0]     w_ppn1,

    output logic [31:0]          pa_i,
    output logic [31:0]          pa_d,
    output logic                 miss_i,
    output logic                 miss_d,
    output logic                 inval_i,
    output logic                 inval_d
);

    tlb_entry_if  ent ();
    tlb_result_if res_i ();  // fetch port.
    tlb_result_if res_d ();  // data port.

    tlb_array i_array (
        .clk(clk), .rstn(rstn),
        .we(tlb_we), .windex(tlb_windex),
        .w_e(w_e), .w_g(w_g), .w_asid(w_asid), .w_ps(w_ps), .w_vppn(w_vppn),
        .w_v0(w_v0), .w_v1(w_v1), .w_ppn0(w_ppn0), .w_ppn1(w_ppn1),
        .ent(ent)
    );

    tlb_match i_match_i (
        .clk(clk), .rstn(rstn), .va(va_i), .csr_asid(csr_asid), .ent(ent), .res(res_i)
    );

    tlb_match i_match_d (
        .clk(clk), .rstn(rstn), .va(va_d), .csr_asid(csr_asid), .ent(ent), .res(res_d)
    );

    addr_translate i_xlate_i (
        .clk(clk), .rstn(rstn), .va(va_i), .pg(pg),
        .dmw0_vseg(dmw0_vseg), .dmw0_pseg(dmw0_pseg),
        .dmw1_vseg(dmw1_vseg), .dmw1_pseg(dmw1_pseg),
        .res(res_i), .pa(pa_i), .miss(miss_i), .inval(inval_i)
    );

    addr_translate i_xlate_d (
        .clk(clk), .rstn(rstn), .va(va_d), .pg(pg),
        .dmw0_vseg(dmw0_vseg), .dmw0_pseg(dmw0_pseg),
        .dmw1_vseg(dmw1_vseg), .dmw1_pseg(dmw1_pseg),
        .res(res_d), .pa(pa_d), .miss(miss_d), .inval(inval_d)
    );

endmodule

// ==== verification/mmu_sva.sv ====
module mmu_sva (
    input logic        clk,
    input logic        rstn,
    input logic        pg,
    input logic [31:0] va_i,
    input logic [31:0] va_d,
    input logic [31:0] pa_i,
    input logic [31:0] pa_d,
    input logic        miss_i,
    input logic        miss_d,
    input logic        inval_i,
    input logic        inval_d
);

    logic lookup_seen;  // set once an address or pg has been sampled.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lookup_seen <= 1'b0;
        end else if (pg || va_i != '0 || va_d != '0) begin
            lookup_seen <= 1'b1;
        end
    end

    excl_i: assert property (@(posedge clk) disable iff (!rstn) !(miss_i && inval_i))
        else $error("fetch port raised miss and inval together");

    excl_d: assert property (@(posedge clk) disable iff (!rstn) !(miss_d && inval_d))
        else $error("data port raised miss and inval together");

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !lookup_seen |-> (pa_i == '0 && pa_d == '0 && !miss_i && !miss_d && !inval_i && !inval_d))
        else $error("outputs moved before the first lookup");

    bypass_i: assert property (@(posedge clk) disable iff (!rstn)
        !$past(pg) |-> (!miss_i && pa_i == $past(va_i)))
        else $error("fetch port did not pass va through with paging off");

    bypass_d: assert property (@(posedge clk) disable iff (!rstn)
        !$past(pg) |-> (!miss_d && pa_d == $past(va_d)))
        else $error("data port did not pass va through with paging off");

endmodule

bind mmu_top mmu_sva i_sva (
    .clk(clk), .rstn(rstn), .pg(pg), .va_i(va_i), .va_d(va_d),
    .pa_i(pa_i), .pa_d(pa_d), .miss_i(miss_i), .miss_d(miss_d),
    .inval_i(inval_i), .inval_d(inval_d)
);

// ==== verification/mmu_tb.sv ====
module mmu_tb import tlb_pkg::*; ();

    logic                 clk;
    logic                 rstn;
    logic [asid_w-1:0]    csr_asid;
    logic                 pg;
    logic [seg_w-1:0]     dmw0_vseg;
    logic [seg_w-1:0]     dmw0_pseg;
    logic [seg_w-1:0]     dmw1_vseg;
    logic [seg_w-1:0]     dmw1_pseg;
    logic [31:0]          va_i;
    logic [31:0]          va_d;
    logic                 tlb_we;
    logic [tlb_idx_w-1:0] tlb_windex;
    logic                 w_e;
    logic [asid_w-1:0]    w_asid;
    logic                 w_g;
    logic [ps_w-1:0]      w_ps;
    logic [vppn_w-1:0]    w_vppn;
    logic                 w_v0;
    logic [ppn_w-1:0]     w_ppn0;
    logic                 w_v1;
    logic [ppn_w-1:0]     w_ppn1;
    logic [31:0]          pa_i;
    logic [31:0]          pa_d;
    logic                 miss_i;
    logic                 miss_d;
    logic                 inval_i;
    logic                 inval_d;

    // each row of the table is either a write or a lookup.
    bit kind_q[$];  // 1 marks a lookup row.
    logic [tlb_idx_w+2+asid_w+ps_w+vppn_w+2+2*ppn_w-1:0] wr_q[$];
    logic [asid_w+4*seg_w:0] ctx_q[$];  // csr_asid, pg and the four window segments.
    logic [63:0]             va_q[$];   // fetch address above data address.
    logic [67:0]             exp_q[$];  // pa, miss and inval for fetch and then for data.
    logic [4*seg_w-1:0]      cur_dmw;

    bit table_ready;
    int checks;
    int errors;

    mmu_top i_dut (
        .clk(clk), .rstn(rstn), .csr_asid(csr_asid), .pg(pg),
        .dmw0_vseg(dmw0_vseg), .dmw0_pseg(dmw0_pseg),
        .dmw1_vseg(dmw1_vseg), .dmw1_pseg(dmw1_pseg),
        .va_i(va_i), .va_d(va_d),
        .tlb_we(tlb_we), .tlb_windex(tlb_windex),
        .w_e(w_e), .w_asid(w_asid), .w_g(w_g), .w_ps(w_ps), .w_vppn(w_vppn),
        .w_v0(w_v0), .w_ppn0(w_ppn0), .w_v1(w_v1), .w_ppn1(w_ppn1),
        .pa_i(pa_i), .pa_d(pa_d), .miss_i(miss_i), .miss_d(miss_d),
        .inval_i(inval_i), .inval_d(inval_d)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic set_windows(input logic [seg_w-1:0] v0, input logic [seg_w-1:0] p0,
                               input logic [seg_w-1:0] v1, input logic [seg_w-1:0] p1);
        cur_dmw = {v0, p0, v1, p1};
    endtask

    task automatic add_write(
        input logic [tlb_idx_w-1:0] idx, input logic e, input logic g,
        input logic [asid_w-1:0] asid, input logic [ps_w-1:0] ps,
        input logic [vppn_w-1:0] vppn, input logic v0, input logic [ppn_w-1:0] ppn0,
        input logic v1, input logic [ppn_w-1:0] ppn1);
        kind_q.push_back(1'b0);
        wr_q.push_back({idx, e, g, asid, ps, vppn, v0, ppn0, v1, ppn1});
    endtask

    // flags are given as {miss, inval}.
    task automatic add_lookup(
        input logic [asid_w-1:0] asid, input logic pg_set,
        input logic [31:0] vi, input logic [31:0] pi, input logic [1:0] fi,
        input logic [31:0] vd, input logic [31:0] pd, input logic [1:0] fd);
        kind_q.push_back(1'b1);
        ctx_q.push_back({asid, pg_set, cur_dmw});
        va_q.push_back({vi, vd});
        exp_q.push_back({pi, fi, pd, fd});
    endtask

    task automatic build_table();
        set_windows(3'd4, 3'd1, 3'd5, 3'd2);
        add_lookup(10'h000, 1'b0, 32'h1234_5678, 32'h1234_5678, 2'b00,
                   32'hffff_0004, 32'hffff_0004, 2'b00);
        add_lookup(10'h000, 1'b0, 32'h9234_5678, 32'h9234_5678, 2'b00,
                   32'ha000_1234, 32'ha000_1234, 2'b00);
        add_lookup(10'h000, 1'b1, 32'h9234_5678, 32'h3234_5678, 2'b00,
                   32'ha000_1234, 32'h4000_1234, 2'b00);
        set_windows(3'd5, 3'd3, 3'd5, 3'd6);
        add_lookup(10'h000, 1'b1, 32'habcd_0000, 32'h6bcd_0000, 2'b00,
                   32'h1000_0000, 32'h0000_0000, 2'b10);  // the TLB is still empty.
        set_windows(3'd6, 3'd0, 3'd7, 3'd0);
        add_write(4'd0, 1'b1, 1'b0, 10'h001, 6'd12, 19'h00201, 1'b1, 20'h12345, 1'b1, 20'h6789a);
        add_write(4'd1, 1'b1, 1'b1, 10'h3ff, 6'd12, 19'h08000, 1'b1, 20'habcde, 1'b0, 20'h11111);
        add_lookup(10'h001, 1'b1, 32'h0040_2abc, 32'h1234_5abc, 2'b00,
                   32'h1000_0123, 32'habcd_e123, 2'b00);
        add_lookup(10'h001, 1'b1, 32'h0040_3def, 32'h6789_adef, 2'b00,
                   32'h1000_1456, 32'h0000_0000, 2'b01);
        // the low ten vppn bits of a 4 MB pair do not take part in the compare.
        add_write(4'd6, 1'b1, 1'b1, 10'h000, 6'd22, 19'h28455, 1'b1, 20'hc0000, 1'b1, 20'hdec00);
        add_lookup(10'h001, 1'b1, 32'h5092_3456, 32'hc012_3456, 2'b00,
                   32'h50c0_0abc, 32'hdec0_0abc, 2'b00);
        add_write(4'd2, 1'b1, 1'b0, 10'h055, 6'd12, 19'h10000, 1'b1, 20'h33333, 1'b1, 20'h34343);
        add_write(4'd3, 1'b0, 1'b1, 10'h000, 6'd12, 19'h18000, 1'b1, 20'h77777, 1'b1, 20'h78787);
        add_lookup(10'h002, 1'b1, 32'h0040_2abc, 32'h0000_0000, 2'b10,
                   32'h2000_0010, 32'h0000_0000, 2'b10);
        add_write(4'd2, 1'b1, 1'b1, 10'h055, 6'd12, 19'h10000, 1'b1, 20'h33333, 1'b1, 20'h34343);
        add_lookup(10'h002, 1'b1, 32'h3000_0040, 32'h0000_0000, 2'b10,
                   32'h2000_0010, 32'h3333_3010, 2'b00);
        add_write(4'd5, 1'b1, 1'b1, 10'h000, 6'd12, 19'h20000, 1'b1, 20'h55555, 1'b1, 20'h56565);
        add_lookup(10'h001, 1'b1, 32'h4000_0abc, 32'h5555_5abc, 2'b00,
                   32'h0040_3def, 32'h6789_adef, 2'b00);
        add_write(4'd4, 1'b1, 1'b1, 10'h000, 6'd12, 19'h20000, 1'b1, 20'h44444, 1'b1, 20'h45454);
        add_lookup(10'h001, 1'b1, 32'h4000_0abc, 32'h4444_4abc, 2'b00,
                   32'h4000_1abc, 32'h4545_4abc, 2'b00);
        add_write(4'd1, 1'b1, 1'b1, 10'h3ff, 6'd12, 19'h08000, 1'b1, 20'habcde, 1'b1, 20'h22222);
        add_lookup(10'h001, 1'b1, 32'h1000_0123, 32'habcd_e123, 2'b00,
                   32'h1000_1456, 32'h2222_2456, 2'b00);
        add_lookup(10'h001, 1'b0, 32'h0040_2abc, 32'h0040_2abc, 2'b00,
                   32'h2000_0010, 32'h2000_0010, 2'b00);
    endtask

    task automatic check_value(input string step, input string name,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error: %s %s expected 0x%08h actual 0x%08h", step, name, exp, act);
        end
    endtask

    task automatic apply_write(input int n);
        {tlb_windex, w_e, w_g, w_asid, w_ps, w_vppn,
         w_v0, w_ppn0, w_v1, w_ppn1} = wr_q[n];
        tlb_we = 1'b1;
        @(negedge clk);
        tlb_we = 1'b0;  // idle cycle so the next lookup compares against the new entry.
        @(negedge clk);
    endtask

    task automatic apply_lookup(input int row, input int n);
        logic [31:0] e_pa_i;
        logic [31:0] e_pa_d;
        logic        e_miss_i;
        logic        e_miss_d;
        logic        e_inval_i;
        logic        e_inval_d;
        string       step;
        {csr_asid, pg, dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg} = ctx_q[n];
        {va_i, va_d} = va_q[n];
        {e_pa_i, e_miss_i, e_inval_i, e_pa_d, e_miss_d, e_inval_d} = exp_q[n];
        step = $sformatf("row %0d", row);
        @(negedge clk);
        check_value(step, "pa_i", e_pa_i, pa_i);
        check_value(step, "miss_i", 32'(e_miss_i), 32'(miss_i));
        check_value(step, "inval_i", 32'(e_inval_i), 32'(inval_i));
        check_value(step, "pa_d", e_pa_d, pa_d);
        check_value(step, "miss_d", 32'(e_miss_d), 32'(miss_d));
        check_value(step, "inval_d", 32'(e_inval_d), 32'(inval_d));
    endtask

    initial begin
        int n_wr;
        int n_lk;
        n_wr = 0;
        n_lk = 0;
        checks = 0;
        errors = 0;
        rstn = 1'b0;
        csr_asid = '0;
        // only the cleared registers keep the outputs at zero while paging is on in reset.
        pg = 1'b1;
        dmw0_vseg = '0;
        dmw0_pseg = '0;
        dmw1_vseg = '0;
        dmw1_pseg = '0;
        va_i = 32'h1234_5678;
        va_d = 32'h9abc_def0;
        tlb_we = 1'b0;
        tlb_windex = '0;
        {w_e, w_asid, w_g, w_ps, w_vppn, w_v0, w_ppn0, w_v1, w_ppn1} = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(negedge clk);
        check_value("reset", "pa_i", 32'h0, pa_i);
        check_value("reset", "pa_d", 32'h0, pa_d);
        check_value("reset", "miss_i", 32'h0, 32'(miss_i));
        check_value("reset", "miss_d", 32'h0, 32'(miss_d));
        check_value("reset", "inval_i", 32'h0, 32'(inval_i));
        check_value("reset", "inval_d", 32'h0, 32'(inval_d));
        pg = 1'b0;
        va_i = '0;
        va_d = '0;
        rstn = 1'b1;
        @(negedge clk);
        for (int r = 0; r < kind_q.size(); r++) begin
            if (kind_q[r]) begin
                apply_lookup(r, n_lk);
                n_lk++;
            end else begin
                apply_write(n_wr);
                n_wr++;
            end
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = (kind_q.size() * 2 + 15) * 20;  // two cycles per row plus reset and some slack.
        #(limit);
        $display("timeout: the table did not finish within %0d time units", limit);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
common/tlb_pkg.sv
common/tlb_entry_if.sv
common/tlb_result_if.sv
tlb/tlb_array.sv
tlb/tlb_match.sv
logic/addr_translate.sv
logic/mmu_top.sv
verification/mmu_sva.sv
verification/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module mmu_tb -Mdir obj_dir -o mmu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mmu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1
